//--- rx_deser_pkg.sv
`default_nettype none

package rx_deser_pkg;

  // ==========================================================================
  // Lane symbol and frame word geometry
  // ==========================================================================

  localparam int SYM_W         = 10;  // Bits per lane symbol.
  localparam int SYMS_PER_WORD = 4;   // Symbols gathered per frame.

  typedef logic [SYM_W-1:0] symbol_t;

  // Oldest symbol lands in the high bits.
  typedef struct packed {
    symbol_t sym3;  // Oldest.
    symbol_t sym2;
    symbol_t sym1;
    symbol_t sym0;  // Newest.
  } frame_word_t;

  typedef logic [$clog2(SYMS_PER_WORD)-1:0] phase_t;

  // ==========================================================================
  // Word alignment
  // ==========================================================================

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    SEARCH  = 3'd1,
    SETTLE  = 3'd2,
    CONFIRM = 3'd3,
    LOCKED  = 3'd4
  } align_state_t;

  // No rotation of these symbols matches, so only one phase can lock.
  localparam frame_word_t TRAIN_WORD = '{
    sym3: 10'h3FF,
    sym2: 10'h000,
    sym1: 10'h155,
    sym0: 10'h2AA
  };

endpackage

`default_nettype wire

//--- lane_gearbox.sv
`timescale 1ns/1ns
`default_nettype none

module lane_gearbox (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  rx_deser_pkg::symbol_t     i_sym,
  input  logic                      i_frame_strobe,
  output rx_deser_pkg::frame_word_t o_word,
  output logic                      o_word_valid
);

  localparam int HIST_D = rx_deser_pkg::SYMS_PER_WORD - 1;

  rx_deser_pkg::symbol_t     hist [HIST_D];  // Index 0 is the newest.
  rx_deser_pkg::frame_word_t capture;

  // ==========================================================================
  // Symbol history
  // ==========================================================================

  always_ff @(posedge i_clk) begin
    hist[0] <= i_sym;
    for (int k = 1; k < HIST_D; k++) begin
      hist[k] <= hist[k-1];
    end
  end

  // ==========================================================================
  // Frame capture
  // ==========================================================================

  // History plus the symbol arriving at this edge.
  always_comb begin
    capture.sym3 = hist[2];
    capture.sym2 = hist[1];
    capture.sym1 = hist[0];
    capture.sym0 = i_sym;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_word       <= '0;
      o_word_valid <= 1'b0;
    end else begin
      o_word_valid <= i_frame_strobe;  // One cycle per frame.
      if (i_frame_strobe) begin
        o_word <= capture;
      end
    end
  end

endmodule

`default_nettype wire

//--- word_align_sm.sv
`timescale 1ns/1ns
`default_nettype none

module word_align_sm #(
  parameter int CONFIRM_COUNT = 3
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_align_en,
  input  rx_deser_pkg::frame_word_t i_word0,
  input  logic                      i_word0_valid,
  output logic                      o_frame_strobe,
  output logic                      o_data_locked
);

  localparam int CNT_W = $clog2(CONFIRM_COUNT + 1);

  rx_deser_pkg::phase_t       frame_cnt;
  rx_deser_pkg::phase_t       phase;
  rx_deser_pkg::phase_t       phase_nxt;
  rx_deser_pkg::align_state_t state;
  rx_deser_pkg::align_state_t state_nxt;
  logic [CNT_W-1:0]           match_cnt;
  logic [CNT_W-1:0]           match_cnt_nxt;
  logic                       word_match;

  // ==========================================================================
  // Frame phase and strobe
  // ==========================================================================

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      frame_cnt <= '0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;  // Free running.
    end
  end

  assign o_frame_strobe = i_align_en && (frame_cnt == phase);  // No frames while disabled.
  assign word_match     = (i_word0 == rx_deser_pkg::TRAIN_WORD);

  // ==========================================================================
  // Training search
  // ==========================================================================

  always_comb begin
    state_nxt     = state;
    phase_nxt     = phase;
    match_cnt_nxt = match_cnt;
    case (state)
      rx_deser_pkg::IDLE: begin
        if (i_align_en) begin
          state_nxt = rx_deser_pkg::SEARCH;
        end
      end
      rx_deser_pkg::SEARCH: begin
        if (i_word0_valid && word_match) begin
          match_cnt_nxt = CNT_W'(1);
          state_nxt     = (CONFIRM_COUNT <= 1) ? rx_deser_pkg::LOCKED : rx_deser_pkg::CONFIRM;
        end else if (i_word0_valid) begin
          phase_nxt = phase + 1'b1;  // Slip one symbol.
          state_nxt = rx_deser_pkg::SETTLE;
        end
      end
      rx_deser_pkg::SETTLE: begin
        if (i_word0_valid) begin
          state_nxt = rx_deser_pkg::SEARCH;  // First word after the slip is dropped.
        end
      end
      rx_deser_pkg::CONFIRM: begin
        if (i_word0_valid && !word_match) begin
          match_cnt_nxt = '0;
          state_nxt     = rx_deser_pkg::SEARCH;
        end else if (i_word0_valid && (match_cnt == CNT_W'(CONFIRM_COUNT - 1))) begin
          state_nxt = rx_deser_pkg::LOCKED;
        end else if (i_word0_valid) begin
          match_cnt_nxt = match_cnt + 1'b1;
        end
      end
      rx_deser_pkg::LOCKED: begin
        state_nxt = rx_deser_pkg::LOCKED;  // Payload is not compared.
      end
      default: begin
        state_nxt = rx_deser_pkg::IDLE;
      end
    endcase
    // Enable low always restarts alignment.
    if (!i_align_en) begin
      state_nxt     = rx_deser_pkg::IDLE;
      phase_nxt     = '0;
      match_cnt_nxt = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state     <= rx_deser_pkg::IDLE;
      phase     <= '0;
      match_cnt <= '0;
    end else begin
      state     <= state_nxt;
      phase     <= phase_nxt;
      match_cnt <= match_cnt_nxt;
    end
  end

  assign o_data_locked = (state == rx_deser_pkg::LOCKED);

endmodule

`default_nettype wire

//--- rx_deser_top.sv
`timescale 1ns/1ns
`default_nettype none

module rx_deser_top #(
  parameter int NUM_LANES     = 4,
  parameter int CONFIRM_COUNT = 3
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_align_en,
  input  rx_deser_pkg::symbol_t     i_lanes [NUM_LANES],
  output rx_deser_pkg::frame_word_t o_words [NUM_LANES],
  output logic                      o_word_valid,
  output logic                      o_data_locked
);

  logic                 frame_strobe;  // Shared phase for all lanes.
  logic [NUM_LANES-1:0] lane_valid;

  // ==========================================================================
  // Per-lane 10-to-40 gearboxes
  // ==========================================================================

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    lane_gearbox u_gearbox (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_sym          (i_lanes[g]),
      .i_frame_strobe (frame_strobe),
      .o_word         (o_words[g]),
      .o_word_valid   (lane_valid[g])
    );
  end

  // ==========================================================================
  // Alignment on lane 0
  // ==========================================================================

  word_align_sm #(
    .CONFIRM_COUNT (CONFIRM_COUNT)
  ) u_align (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_align_en     (i_align_en),
    .i_word0        (o_words[0]),
    .i_word0_valid  (lane_valid[0]),
    .o_frame_strobe (frame_strobe),
    .o_data_locked  (o_data_locked)
  );

  assign o_word_valid = lane_valid[0];  // All lanes pulse together.

endmodule

`default_nettype wire

//--- tb_rx_deser.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rx_deser;

  localparam int NUM_LANES      = 4;
  localparam int CONFIRM_COUNT  = 3;
  localparam int CLK_HALF       = 4;
  localparam int LOCK_TIMEOUT   = 100;  // Cycles from enable to lock.
  localparam int VALID_TIMEOUT  = 12;
  localparam int CLEAR_TIMEOUT  = 4;
  localparam int TRAIN_CHECKS   = 6;
  localparam int PAYLOAD_CYCLES = 40;

  localparam logic [39:0] TRAIN_WORD_EXP = {10'h3FF, 10'h000, 10'h155, 10'h2AA};

  logic                      i_clk;
  logic                      i_rst_n;
  logic                      i_align_en;
  rx_deser_pkg::symbol_t     i_lanes [NUM_LANES];
  rx_deser_pkg::frame_word_t o_words [NUM_LANES];
  logic                      o_word_valid;
  logic                      o_data_locked;

  logic [9:0] hist [NUM_LANES][4];  // Index 0 is the newest sample.
  logic       en_at_edge;
  int         seed;
  int         errors;
  int         checks;
  bit         timed_out;
  bit         train_mode;
  int         train_idx;

  rx_deser_top #(
    .NUM_LANES     (NUM_LANES),
    .CONFIRM_COUNT (CONFIRM_COUNT)
  ) DUT (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_align_en    (i_align_en),
    .i_lanes       (i_lanes),
    .o_words       (o_words),
    .o_word_valid  (o_word_valid),
    .o_data_locked (o_data_locked)
  );

  initial begin
    i_clk = 1'b0;
    forever #CLK_HALF i_clk = ~i_clk;
  end

  // ==========================================================================
  // Reference model and checking
  // ==========================================================================

  function automatic logic [9:0] train_sym(input int idx);
    case (idx % 4)
      0:       train_sym = 10'h3FF;
      1:       train_sym = 10'h000;
      2:       train_sym = 10'h155;
      default: train_sym = 10'h2AA;
    endcase
  endfunction

  // Oldest of the four sampled symbols goes to the high bits.
  function automatic logic [39:0] expected_word(input int lane);
    expected_word = {hist[lane][3], hist[lane][2], hist[lane][1], hist[lane][0]};
  endfunction

  task automatic check_value(input string name, input logic [39:0] expected,
                             input logic [39:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic timeout_error(input string what);
    errors++;
    timed_out = 1'b1;
    $display("ERROR: timed out waiting for %s at %0t", what, $time);
  endtask

  // Symbols seen by the DUT at each rising edge.
  always @(posedge i_clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int k = 3; k > 0; k--) begin
        hist[l][k] = hist[l][k-1];
      end
      hist[l][0] = i_lanes[l];
    end
    en_at_edge = i_align_en;
  end

  always @(negedge i_clk) begin
    if (i_rst_n === 1'b1 && o_word_valid === 1'b1) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        check_value($sformatf("lane %0d word", l), expected_word(l), o_words[l]);
      end
    end
    if (i_rst_n === 1'b1 && en_at_edge === 1'b0) begin
      check_value("valid while disabled", 40'd0, {39'd0, o_word_valid});
      check_value("locked while disabled", 40'd0, {39'd0, o_data_locked});
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  task automatic drive_lanes();
    for (int l = 0; l < NUM_LANES; l++) begin
      i_lanes[l] = 10'($random(seed));
    end
    if (train_mode) begin
      i_lanes[0] = train_sym(train_idx);
      train_idx  = (train_idx + 1) % 4;
    end
  endtask

  task automatic step_cycle();
    @(posedge i_clk);
    #1;
    drive_lanes();
  endtask

  task automatic wait_valid(input string what);
    int n;
    n = 0;
    step_cycle();
    while (o_word_valid !== 1'b1 && n < VALID_TIMEOUT) begin
      step_cycle();
      n++;
    end
    if (o_word_valid !== 1'b1) begin
      timeout_error(what);
    end
  endtask

  task automatic wait_locked(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (o_data_locked !== level && n < limit) begin
      step_cycle();
      n++;
    end
    if (o_data_locked !== level) begin
      timeout_error(what);
    end
  endtask

  // Disable, restart training at an offset, lock, then switch to payload.
  task automatic run_round(input int off);
    int n;
    i_align_en = 1'b0;
    step_cycle();
    wait_locked(1'b0, CLEAR_TIMEOUT, "lock to clear");
    if (timed_out) return;
    train_mode = 1'b1;
    train_idx  = off;
    step_cycle();
    i_align_en = 1'b1;
    wait_locked(1'b1, LOCK_TIMEOUT, $sformatf("lock at offset %0d", off));
    if (timed_out) return;
    for (n = 0; n < TRAIN_CHECKS; n++) begin
      wait_valid("valid after lock");
      if (timed_out) return;
      check_value("lane 0 training word", TRAIN_WORD_EXP, o_words[0]);
    end
    train_mode = 1'b0;
    for (n = 0; n < PAYLOAD_CYCLES; n++) begin
      step_cycle();
      check_value("locked during payload", 40'd1, {39'd0, o_data_locked});
    end
  endtask

  initial begin
    int start_off;
    seed       = 32'h9ca8efac;
    errors     = 0;
    checks     = 0;
    timed_out  = 1'b0;
    train_mode = 1'b0;
    train_idx  = 0;
    i_rst_n    = 1'b0;
    i_align_en = 1'b0;
    en_at_edge = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int k = 0; k < 4; k++) begin
        hist[l][k] = 10'd0;
      end
    end
    start_off = $random(seed) & 3;
    drive_lanes();

    repeat (3) step_cycle();
    i_rst_n = 1'b1;
    check_value("valid after reset", 40'd0, {39'd0, o_word_valid});
    check_value("locked after reset", 40'd0, {39'd0, o_data_locked});

    for (int n = 0; n < 8; n++) begin
      step_cycle();
      check_value("locked with enable low", 40'd0, {39'd0, o_data_locked});
    end

    // All four start offsets, each one a relock after disable.
    for (int k = 0; k < 4; k++) begin
      if (!timed_out) begin
        run_round((start_off + k) % 4);
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rx_deser_pkg.sv
lane_gearbox.sv
word_align_sm.sv
rx_deser_top.sv
tb_rx_deser.sv

//--- Makefile
# Verilator build, run, lint and clean for the lane deserializer.

VERILATOR ?= verilator
TOP       ?= tb_rx_deser
RTL_TOP   ?= rx_deser_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= rx_deser_pkg.sv lane_gearbox.sv word_align_sm.sv rx_deser_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation passed" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
